/* src/hk_defines.svh */
`ifndef HK_DEFINES_SVH
`define HK_DEFINES_SVH

// widths
`define HK_BUS_W     32                      // system bus data and address
`define HK_SEL_W     4                       // byte select
`define HK_DEC_W     20                      // address bits used by the decoder
`define HK_DNA_W     57                      // device DNA length
`define HK_CNT_W     9                       // DNA sequencer count
`define HK_DWL       8                       // LED data width
`define HK_DWE       8                       // expansion width per group

// register offsets, compared on sys_addr[19:0]
`define HK_REG_ID        20'h00000
`define HK_REG_DNA_LO    20'h00004
`define HK_REG_DNA_HI    20'h00008
`define HK_REG_LOOP      20'h0000C
`define HK_REG_EXP_P_OE  20'h00010
`define HK_REG_EXP_N_OE  20'h00014
`define HK_REG_EXP_P_O   20'h00018
`define HK_REG_EXP_N_O   20'h0001C
`define HK_REG_EXP_P_I   20'h00020
`define HK_REG_EXP_N_I   20'h00024
`define HK_REG_STATUS    20'h00028
`define HK_REG_LED       20'h00030

// identity
`define HK_DNA_SIM   57'h1_5a3c_9e0f_b724_d8 // value the DNA model loads
`define HK_ID_BOARD  4'h1                    // board type, release 1
`define HK_DNA_END   9'd465                  // readout done past this count

`endif

/* src/hk_pkg.sv */
`default_nettype none

`include "hk_defines.svh"

package hk_pkg;

  //////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////

  // one word address, only the low bits get decoded
  typedef logic [`HK_BUS_W-1:0] hk_addr_t;

  // read and write data word
  typedef logic [`HK_BUS_W-1:0] hk_data_t;

  // byte select, full word accesses only
  typedef logic [`HK_SEL_W-1:0] hk_sel_t;

  //////////////////////////////////////////////////////////
  // device identity
  //////////////////////////////////////////////////////////

  // on-die unique identifier, MSB leaves the port first
  typedef logic [`HK_DNA_W-1:0] dna_t;

endpackage : hk_pkg

`default_nettype wire

/* src/dna_port_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hk_defines.svh"

// stand-in for the vendor DNA port primitive
// read loads the fused value, shift moves it out MSB first
module dna_port_model import hk_pkg::*; (
  input  logic clk_i,    // slow DNA clock from the reader
  input  logic read_i,   // load the identifier
  input  logic shift_i,  // shift one bit toward the MSB
  output logic dout_o    // serial data out
);

  ////////////////////////////////////////////////////////////
  // shift register
  ////////////////////////////////////////////////////////////

  dna_t dna_sr;  // holds the identifier while it is shifted out

  // load wins over shift, as on the real port
  always_ff @(posedge clk_i) begin
    if (read_i) begin
      dna_sr <= `HK_DNA_SIM;
    end else if (shift_i) begin
      dna_sr <= {dna_sr[`HK_DNA_W-2:0], 1'b0};  // no user data, zero fill
    end
  end

  ////////////////////////////////////////////////////////////
  // serial output
  ////////////////////////////////////////////////////////////

  // current MSB is visible before the next shift edge
  assign dout_o = dna_sr[`HK_DNA_W-1];

endmodule : dna_port_model

`default_nettype wire

/* src/dna_reader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hk_defines.svh"

// startup sequencer for the DNA readout
// one pass after reset, then holds the value
module dna_reader import hk_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic dna_dout_i,   // serial data from the DNA port
  output logic dna_clk_o,    // slow port clock, 8 system clocks per period
  output logic dna_read_o,   // load window
  output logic dna_shift_o,  // shift window
  output dna_t dna_value_o,  // collected identifier
  output logic dna_done_o    // readout complete
);

  // window limits on the sequencer count
  localparam logic [`HK_CNT_W-1:0] READ_END    = 9'd10;  // load below this
  localparam logic [`HK_CNT_W-1:0] SHIFT_START = 9'd18;  // shift above this

  logic [`HK_CNT_W-1:0] dna_cnt;  // sequencer count
  logic                 sample;   // take one bit this cycle

  ////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dna_cnt     <= '0;
      dna_clk_o   <= 1'b0;
      dna_read_o  <= 1'b0;
      dna_shift_o <= 1'b0;
      dna_done_o  <= 1'b0;
    end else begin
      if (!dna_done_o) begin
        dna_cnt <= dna_cnt + 9'd1;  // freezes once done
      end
      dna_clk_o   <= dna_cnt[2];              // rises on count 4, 12, 20 ...
      dna_read_o  <= (dna_cnt < READ_END);    // covers the first clock edge
      dna_shift_o <= (dna_cnt > SHIFT_START); // from the third edge on
      if (dna_cnt > `HK_DNA_END) begin
        dna_done_o <= 1'b1;                   // sticky until reset
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bit capture
  ////////////////////////////////////////////////////////////

  // mid-way between two port clock edges, the data is settled
  assign sample = (dna_cnt[2:0] == 3'd0) && !dna_done_o;

  // early samples before the load fall out the top
  always_ff @(posedge clk) begin
    if (sample) begin
      dna_value_o <= {dna_value_o[`HK_DNA_W-2:0], dna_dout_i};
    end
  end

endmodule : dna_reader

`default_nettype wire

/* src/hk_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hk_defines.svh"

// register bank on the system bus
// ID, DNA, loopback flag, expansion pins, status and LEDs
module hk_regs import hk_pkg::*; #(
  parameter int unsigned DWL = `HK_DWL,  // LED width
  parameter int unsigned DWE = `HK_DWE   // expansion width per group
) (
  input  logic           clk,
  input  logic           rstn,
  // system bus
  input  hk_addr_t       sys_addr_i,
  input  hk_data_t       sys_wdata_i,
  input  hk_sel_t        sys_sel_i,       // full words only, not decoded
  input  logic           sys_wen_i,       // write strobe
  input  logic           sys_ren_i,       // read strobe
  output hk_data_t       sys_rdata_o,
  output logic           sys_ack_o,       // one clock after the strobe
  output logic           sys_err_o,       // high while in reset
  // identity
  input  dna_t           dna_value_i,
  input  logic           dna_done_i,
  // board pins
  output logic [DWL-1:0] led_o,
  output logic           digital_loop_o,
  input  logic [DWE-1:0] exp_p_i,         // raw, not synchronized
  input  logic [DWE-1:0] exp_n_i,
  output logic [DWE-1:0] exp_p_o,
  output logic [DWE-1:0] exp_p_oe,
  output logic [DWE-1:0] exp_n_o,
  output logic [DWE-1:0] exp_n_oe
);

  logic [`HK_DEC_W-1:0] reg_addr;   // decoded part of the address
  logic                 sys_en;     // any access this cycle
  hk_data_t             id_value;   // design identification word
  hk_data_t             rdata_mux;  // read value before the output register

  assign reg_addr = sys_addr_i[`HK_DEC_W-1:0];
  assign sys_en   = sys_wen_i | sys_ren_i;

  // board type in the low nibble, rest reserved
  assign id_value = {{(`HK_BUS_W-4){1'b0}}, `HK_ID_BOARD};

  ////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////

  // writes land on the strobe edge, pins change next cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      digital_loop_o <= 1'b0;
      exp_p_oe       <= '0;
      exp_n_oe       <= '0;
      exp_p_o        <= '0;
      exp_n_o        <= '0;
      led_o          <= '0;
    end else if (sys_wen_i) begin
      case (reg_addr)
        `HK_REG_LOOP:     digital_loop_o <= sys_wdata_i[0];
        `HK_REG_EXP_P_OE: exp_p_oe       <= sys_wdata_i[DWE-1:0];
        `HK_REG_EXP_N_OE: exp_n_oe       <= sys_wdata_i[DWE-1:0];
        `HK_REG_EXP_P_O:  exp_p_o        <= sys_wdata_i[DWE-1:0];
        `HK_REG_EXP_N_O:  exp_n_o        <= sys_wdata_i[DWE-1:0];
        `HK_REG_LED:      led_o          <= sys_wdata_i[DWL-1:0];
        default: ;  // read-only or unmapped, dropped
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_addr)
      `HK_REG_ID:       rdata_mux = id_value;
      `HK_REG_DNA_LO:   rdata_mux = dna_value_i[`HK_BUS_W-1:0];
      `HK_REG_DNA_HI: begin
        rdata_mux = {{(2*`HK_BUS_W-`HK_DNA_W){1'b0}},
                     dna_value_i[`HK_DNA_W-1:`HK_BUS_W]};  // top 25 bits
      end
      `HK_REG_LOOP:     rdata_mux = {{(`HK_BUS_W-1){1'b0}}, digital_loop_o};
      `HK_REG_EXP_P_OE: rdata_mux = {{(`HK_BUS_W-DWE){1'b0}}, exp_p_oe};
      `HK_REG_EXP_N_OE: rdata_mux = {{(`HK_BUS_W-DWE){1'b0}}, exp_n_oe};
      `HK_REG_EXP_P_O:  rdata_mux = {{(`HK_BUS_W-DWE){1'b0}}, exp_p_o};
      `HK_REG_EXP_N_O:  rdata_mux = {{(`HK_BUS_W-DWE){1'b0}}, exp_n_o};
      `HK_REG_EXP_P_I:  rdata_mux = {{(`HK_BUS_W-DWE){1'b0}}, exp_p_i};
      `HK_REG_EXP_N_I:  rdata_mux = {{(`HK_BUS_W-DWE){1'b0}}, exp_n_i};
      `HK_REG_STATUS:   rdata_mux = {{(`HK_BUS_W-1){1'b0}}, dna_done_i};
      `HK_REG_LED:      rdata_mux = {{(`HK_BUS_W-DWL){1'b0}}, led_o};
      default:          rdata_mux = '0;  // unmapped reads zero
    endcase
  end

  ////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////

  // every strobe gets its ack, mapped or not, no wait states
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b1;
    end else begin
      sys_ack_o <= sys_en;
      sys_err_o <= 1'b0;
    end
  end

  // data word only moves on an access
  always_ff @(posedge clk) begin
    if (sys_en) begin
      sys_rdata_o <= rdata_mux;
    end
  end

endmodule : hk_regs

`default_nettype wire

/* src/hk_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hk_defines.svh"

// housekeeping top, DNA readout plus register bank
module hk_top import hk_pkg::*; (
  input  logic               clk,
  input  logic               rstn,
  // system bus
  input  hk_addr_t           sys_addr_i,
  input  hk_data_t           sys_wdata_i,
  input  hk_sel_t            sys_sel_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  output hk_data_t           sys_rdata_o,
  output logic               sys_ack_o,
  output logic               sys_err_o,
  // board pins
  output logic [`HK_DWL-1:0] led_o,
  output logic               digital_loop_o,
  input  logic [`HK_DWE-1:0] exp_p_i,
  input  logic [`HK_DWE-1:0] exp_n_i,
  output logic [`HK_DWE-1:0] exp_p_o,
  output logic [`HK_DWE-1:0] exp_p_oe,
  output logic [`HK_DWE-1:0] exp_n_o,
  output logic [`HK_DWE-1:0] exp_n_oe
);

  ////////////////////////////////////////////////////////////
  // DNA readout
  ////////////////////////////////////////////////////////////

  logic dna_clk;    // slow port clock
  logic dna_read;   // load window
  logic dna_shift;  // shift window
  logic dna_dout;   // serial identifier bit
  dna_t dna_value;  // collected identifier
  logic dna_done;   // readout complete

  dna_reader i_dna_reader (
    .clk         (clk),
    .rstn        (rstn),
    .dna_dout_i  (dna_dout),
    .dna_clk_o   (dna_clk),
    .dna_read_o  (dna_read),
    .dna_shift_o (dna_shift),
    .dna_value_o (dna_value),
    .dna_done_o  (dna_done)
  );

  dna_port_model i_dna_port (
    .clk_i   (dna_clk),
    .read_i  (dna_read),
    .shift_i (dna_shift),
    .dout_o  (dna_dout)
  );

  ////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////

  hk_regs #(
    .DWL (`HK_DWL),
    .DWE (`HK_DWE)
  ) i_hk_regs (
    .clk            (clk),
    .rstn           (rstn),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_sel_i      (sys_sel_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .sys_err_o      (sys_err_o),
    .dna_value_i    (dna_value),
    .dna_done_i     (dna_done),
    .led_o          (led_o),
    .digital_loop_o (digital_loop_o),
    .exp_p_i        (exp_p_i),
    .exp_n_i        (exp_n_i),
    .exp_p_o        (exp_p_o),
    .exp_p_oe       (exp_p_oe),
    .exp_n_o        (exp_n_o),
    .exp_n_oe       (exp_n_oe)
  );

endmodule : hk_top

`default_nettype wire

/* verif/hk_sva.sv */
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the register bank
module hk_sva (
  input logic clk,
  input logic rstn,
  input logic sys_wen_i,
  input logic sys_ren_i,
  input logic sys_ack_i,
  input logic sys_err_i,
  input logic dna_done_i
);

  ////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////

  ack_after_strobe: assert property (@(posedge clk) disable iff (!rstn)
    (sys_wen_i || sys_ren_i) |=> sys_ack_i)
    else $error("no ack one cycle after a strobe");

  ack_needs_strobe: assert property (@(posedge clk) disable iff (!rstn)
    sys_ack_i |-> $past(sys_wen_i || sys_ren_i))
    else $error("ack without a strobe one cycle earlier");

  // err drops on the first edge out of reset
  err_low: assert property (@(posedge clk) disable iff (!rstn)
    $past(rstn) |-> !sys_err_i)
    else $error("sys_err_o high outside reset");

  ////////////////////////////////////////////////////////////
  // DNA readout
  ////////////////////////////////////////////////////////////

  done_sticky: assert property (@(posedge clk) disable iff (!rstn)
    !$fell(dna_done_i))
    else $error("dna_done fell outside reset");

endmodule : hk_sva

bind hk_regs hk_sva i_hk_sva (
  .clk        (clk),
  .rstn       (rstn),
  .sys_wen_i  (sys_wen_i),
  .sys_ren_i  (sys_ren_i),
  .sys_ack_i  (sys_ack_o),
  .sys_err_i  (sys_err_o),
  .dna_done_i (dna_done_i)
);

`default_nettype wire

/* verif/hk_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hk_defines.svh"

module hk_tb import hk_pkg::*; ();

  localparam int ACK_TIMEOUT  = 16;    // cycles
  localparam int DONE_TIMEOUT = 1000;  // cycles

  logic               clk;
  logic               rstn;
  hk_addr_t           sys_addr;
  hk_data_t           sys_wdata;
  hk_sel_t            sys_sel;
  logic               sys_wen;
  logic               sys_ren;
  hk_data_t           sys_rdata;
  logic               sys_ack;
  logic               sys_err;
  logic [`HK_DWL-1:0] led;
  logic               digital_loop;
  logic [`HK_DWE-1:0] exp_p_in, exp_n_in;
  logic [`HK_DWE-1:0] exp_p_out, exp_p_oe, exp_n_out, exp_n_oe;

  // expected pin state from the register rules
  logic               sh_loop;
  logic [`HK_DWL-1:0] sh_led;
  logic [`HK_DWE-1:0] sh_p_o, sh_p_oe, sh_n_o, sh_n_oe;

  logic strobe_q;  // strobe seen on the last rising edge
  logic rstn_q;    // reset state on the last rising edge
  logic done_q;    // readout done on the last falling edge

  int          data_errs, pin_errs, dna_errs, proto_errs;
  logic [31:0] lfsr = 32'hb727;

  hk_top i_hk_top (
    .clk            (clk),
    .rstn           (rstn),
    .sys_addr_i     (sys_addr),
    .sys_wdata_i    (sys_wdata),
    .sys_sel_i      (sys_sel),
    .sys_wen_i      (sys_wen),
    .sys_ren_i      (sys_ren),
    .sys_rdata_o    (sys_rdata),
    .sys_ack_o      (sys_ack),
    .sys_err_o      (sys_err),
    .led_o          (led),
    .digital_loop_o (digital_loop),
    .exp_p_i        (exp_p_in),
    .exp_n_i        (exp_n_in),
    .exp_p_o        (exp_p_out),
    .exp_p_oe       (exp_p_oe),
    .exp_n_o        (exp_n_out),
    .exp_n_oe       (exp_n_oe)
  );

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input hk_data_t got, input hk_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%08h exp 0x%08h at %0t", name, got, exp, $time);
      data_errs++;
    end
  endtask

  task automatic check_pins(input string name, input logic [`HK_DWE-1:0] got,
                            input logic [`HK_DWE-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%02h exp 0x%02h at %0t", name, got, exp, $time);
      pin_errs++;
    end
  endtask

  task automatic check_dna(input string name, input dna_t got, input dna_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%015h exp 0x%015h at %0t", name, got, exp, $time);
      dna_errs++;
    end
  endtask

  task automatic check_all_pins();
    check_pins("digital_loop_o", {{(`HK_DWE-1){1'b0}}, digital_loop},
               {{(`HK_DWE-1){1'b0}}, sh_loop});
    check_pins("led_o", led, sh_led);
    check_pins("exp_p_o", exp_p_out, sh_p_o);
    check_pins("exp_p_oe", exp_p_oe, sh_p_oe);
    check_pins("exp_n_o", exp_n_out, sh_n_o);
    check_pins("exp_n_oe", exp_n_oe, sh_n_oe);
  endtask

  // ack is due now and err must stay low
  task automatic expect_ack(input string what);
    if (!sys_ack) begin
      $display("no ack one cycle after the %s strobe at %0t", what, $time);
      proto_errs++;
    end
    check_pins("sys_err_o", {{(`HK_DWE-1){1'b0}}, sys_err}, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // cycle watch
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    strobe_q <= sys_wen | sys_ren;
    rstn_q   <= rstn;
  end

  // out of reset the ack repeats the last strobe and err stays low
  always @(negedge clk) begin
    if (rstn_q) begin
      check_pins("sys_ack_o", {{(`HK_DWE-1){1'b0}}, sys_ack},
                 {{(`HK_DWE-1){1'b0}}, strobe_q});
      check_pins("sys_err_o", {{(`HK_DWE-1){1'b0}}, sys_err}, '0);
      if (done_q && !i_hk_top.dna_done) begin
        $display("DNA done flag fell outside reset at %0t", $time);
        proto_errs++;
      end
    end
    done_q = i_hk_top.dna_done;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // galois step to the right with taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'ha300_0000;
    return s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // only the control registers move and keep their width
  task automatic shadow_write(input hk_addr_t addr, input hk_data_t data);
    case (addr[`HK_DEC_W-1:0])
      `HK_REG_LOOP:     sh_loop = data[0];
      `HK_REG_EXP_P_OE: sh_p_oe = data[`HK_DWE-1:0];
      `HK_REG_EXP_N_OE: sh_n_oe = data[`HK_DWE-1:0];
      `HK_REG_EXP_P_O:  sh_p_o  = data[`HK_DWE-1:0];
      `HK_REG_EXP_N_O:  sh_n_o  = data[`HK_DWE-1:0];
      `HK_REG_LED:      sh_led  = data[`HK_DWL-1:0];
      default: ;
    endcase
  endtask

  // strobe for one cycle then poll for the ack
  task automatic bus_access(input logic wr, input hk_addr_t addr, input hk_data_t data,
                            output hk_data_t rdata);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge clk);
    if (sys_ack) begin
      $display("ack seen with no access pending at %0t", $time);
      proto_errs++;
    end
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(negedge clk);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    while (!sys_ack && wait_cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!sys_ack) begin
      $display("no ack within %0d cycles for address 0x%08h", ACK_TIMEOUT, addr);
      proto_errs++;
    end else if (wait_cnt != 0) begin
      $display("ack for address 0x%08h came %0d cycles late", addr, wait_cnt);
      proto_errs++;
    end
    check_pins("sys_err_o", {{(`HK_DWE-1){1'b0}}, sys_err}, '0);
    rdata = sys_rdata;
  endtask

  // poll status and then read both DNA words
  task automatic wait_dna_done();
    hk_data_t st, lo, hi;
    dna_t     exp_dna;
    int       cycles;
    exp_dna = `HK_DNA_SIM;
    cycles  = 2;
    bus_access(1'b0, `HK_REG_STATUS, '0, st);
    while (!st[0] && cycles < DONE_TIMEOUT) begin
      bus_access(1'b0, `HK_REG_STATUS, '0, st);
      cycles += 2;  // two clocks per read
    end
    if (!st[0]) begin
      $display("DNA readout not done within %0d cycles", DONE_TIMEOUT);
      proto_errs++;
    end
    bus_access(1'b0, `HK_REG_DNA_LO, '0, lo);
    bus_access(1'b0, `HK_REG_DNA_HI, '0, hi);
    check_data("sys_rdata_o[DNA_HI]", hi, hk_data_t'(exp_dna >> `HK_BUS_W));
    check_dna("dna_value", {hi[`HK_DNA_W-`HK_BUS_W-1:0], lo}, exp_dna);
  endtask

  // write then read LED on consecutive cycles with no idle between pairs
  task automatic led_pairs(input int n);
    logic [31:0] val, prev;
    prev = '0;
    for (int k = 0; k < n; k++) begin
      rand_bits(`HK_DWL, val);
      @(negedge clk);
      if (k > 0) begin
        expect_ack("LED read");
        check_data("sys_rdata_o[LED]", sys_rdata, prev);
      end
      sys_addr  = `HK_REG_LED;
      sys_wdata = val;
      sys_wen   = 1'b1;
      sys_ren   = 1'b0;
      @(negedge clk);
      expect_ack("LED write");
      sh_led = val[`HK_DWL-1:0];
      check_pins("led_o", led, sh_led);
      sys_wen = 1'b0;
      sys_ren = 1'b1;
      prev    = val;
    end
    @(negedge clk);
    expect_ack("LED read");
    check_data("sys_rdata_o[LED]", sys_rdata, prev);
    sys_ren = 1'b0;
  endtask

  task automatic run_case(input logic [31:0] op, addr, wdata, pin_p, pin_n, exp_val);
    hk_data_t rdata;
    exp_p_in = pin_p[`HK_DWE-1:0];
    exp_n_in = pin_n[`HK_DWE-1:0];
    case (op)
      32'h1: begin
        bus_access(1'b1, addr, wdata, rdata);
        shadow_write(addr, wdata);
        check_all_pins();
      end
      32'h2: begin
        bus_access(1'b0, addr, '0, rdata);
        check_data($sformatf("sys_rdata_o[0x%05h]", addr[`HK_DEC_W-1:0]), rdata, exp_val);
      end
      32'h3: wait_dna_done();
      default: begin
        $display("unknown operation %0h in the case file", op);
        proto_errs++;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd, n;
    string       line;
    logic [31:0] op, addr, wdata, pin_p, pin_n, exp_val;
    clk       = 1'b0;
    rstn      = 1'b0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_sel   = '1;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    exp_p_in  = '0;
    exp_n_in  = '0;
    sh_loop   = 1'b0;
    sh_led    = '0;
    sh_p_o    = '0;
    sh_p_oe   = '0;
    sh_n_o    = '0;
    sh_n_oe   = '0;
    repeat (4) @(negedge clk);  // 4 cycles in reset
    // err held high while in reset
    check_pins("sys_err_o", {{(`HK_DWE-1){1'b0}}, sys_err}, {{(`HK_DWE-1){1'b0}}, 1'b1});
    rstn = 1'b1;
    @(negedge clk);
    check_all_pins();  // everything low out of reset
    fd = $fopen("verif/hk_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/hk_cases.txt");
      proto_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h", op, addr, wdata, pin_p, pin_n, exp_val);
          if (n == 6) run_case(op, addr, wdata, pin_p, pin_n, exp_val);  // comment lines drop
        end
      end
      $fclose(fd);
    end
    led_pairs(12);
    $display("errors: data %0d, pins %0d, dna %0d, protocol %0d",
             data_errs, pin_errs, dna_errs, proto_errs);
    if (data_errs + pin_errs + dna_errs + proto_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : hk_tb

`default_nettype wire

/* verif/hk_cases.txt */
// op: 1 write, 2 read, 3 wait for DNA done and check it (other columns unused)
// op addr     wdata    exp_p_i exp_n_i expected_read
2 00000000 00000000 00 00 00000001
2 00000028 00000000 00 00 00000000
2 00000010 00000000 00 00 00000000
1 0000000c ffffffff 00 00 00000000
2 0000000c 00000000 00 00 00000001
1 00000010 123456a5 00 00 00000000
2 00000010 00000000 00 00 000000a5
1 00000014 0000ff3c 00 00 00000000
2 00000014 00000000 00 00 0000003c
1 00000018 abcdef81 00 00 00000000
2 00000018 00000000 00 00 00000081
1 0000001c 0000017e 00 00 00000000
2 0000001c 00000000 00 00 0000007e
1 00000030 deadbe5a 00 00 00000000
2 00000030 00000000 00 00 0000005a
2 00000020 00000000 c3 00 000000c3
2 00000024 00000000 00 96 00000096
3 00000000 00000000 00 00 00000000
2 00000028 00000000 00 00 00000001
1 00000000 ffffffff 00 00 00000000
2 00000000 00000000 00 00 00000001
1 00000004 00000000 00 00 00000000
1 00000008 ffffffff 00 00 00000000
1 00000028 00000000 00 00 00000000
3 00000000 00000000 00 00 00000000
1 00000020 ffffffff 11 22 00000000
2 00000020 00000000 11 22 00000011
2 00000040 00000000 00 00 00000000
1 00000034 ffffffff 00 00 00000000
2 00001030 00000000 00 00 00000000
2 00100030 00000000 00 00 0000005a
1 0000000c 00000002 00 00 00000000
2 0000000c 00000000 00 00 00000000

/* tb.f */
+incdir+src
src/hk_pkg.sv
src/dna_port_model.sv
src/dna_reader.sv
src/hk_regs.sv
src/hk_top.sv
verif/hk_sva.sv
verif/hk_tb.sv

/* Makefile */
# Verilator build and run of the housekeeping testbench
TOP := hk_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o $(TOP)

run: compile
	rm -f sim.log
	-./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -qF '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' sim.log || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir sim.log
